// File: source/reg_mgr_pkg.sv
package reg_mgr_pkg;

  // operation held by the controller until next_state
  typedef enum logic [2:0] {
    // nothing to do, bus outputs stay quiet
    OP_NOP     = 3'd0,
    // latch alu or operand path value
    OP_CATCH   = 3'd1,
    // register fetch from base + reg_num
    OP_READ    = 3'd2,
    // fetch through held pointer
    OP_READ_P  = 3'd3,
    // store with optional post-modify
    OP_WRITE   = 3'd4,
    // store at pointed-to address
    OP_WRITE_P = 3'd5
  } reg_op_e;

  // post-modify flag from the instruction
  typedef enum logic [1:0] {
    STEP_NONE = 2'b00,
    STEP_INC  = 2'b01,
    STEP_DEC  = 2'b10
    // 2'b11 unused, treated as none
  } step_e;

  // bus sequencer state
  typedef enum logic [1:0] {
    // no request outstanding
    SEQ_IDLE = 2'd0,
    // strobe cycle
    SEQ_REQ  = 2'd1,
    // waiting for matching completion
    SEQ_WAIT = 2'd2
  } seq_state_e;

endpackage

// File: source/operand_store.sv
`timescale 1ns/10ps

module operand_store
  import reg_mgr_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  // operation currently held by the controller
  input  reg_op_e           reg_op,
  // register number from the instruction
  input  logic [3:0]        reg_num,
  // base address of the register file in memory
  input  logic [ADDR_W-1:0] base_addr,
  // operand is used as a pointer
  input  logic              is_reg_ptr,
  // post-modify request
  input  step_e             reg_step,
  // selects which path a catch takes
  input  logic              alu_result,
  // value from the alu
  input  logic [DATA_W-1:0] register_in,
  // value from the operand path
  input  logic [DATA_W-1:0] reg_ptr_in,
  // strobes from the sequencer
  input  logic              catch_en,
  input  logic              load_reg,
  input  logic              load_ptr,
  // read data returned with a completion
  input  logic [DATA_W-1:0] data_in,
  output logic [DATA_W-1:0] register_out,
  output logic [DATA_W-1:0] reg_ptr_out,
  output logic [ADDR_W-1:0] target_addr,
  output logic [DATA_W-1:0] write_data
);

  // held register value
  logic [DATA_W-1:0] reg_val;
  // held pointer value
  logic [DATA_W-1:0] ptr_val;

  // value chosen for a store before post-modify
  logic [DATA_W-1:0] save_val;
  // data path is the register itself, not the pointer
  logic              save_reg;
  // address comes from the pointer
  logic              ptr_op;
  // two candidate addresses
  logic [ADDR_W-1:0] ptr_addr;
  logic [ADDR_W-1:0] num_addr;

  // held values update on catch or on a read completion
  always_ff @(posedge clk) begin
    if (rst) begin
      reg_val <= '0;
      ptr_val <= '0;
    end else begin
      if (catch_en) begin
        if (alu_result) begin
          // alu result only touches the register
          reg_val <= register_in;
        end else begin
          // operand path fills both copies
          reg_val <= reg_ptr_in;
          ptr_val <= reg_ptr_in;
        end
      end else begin
        if (load_reg) begin
          reg_val <= data_in;
        end
        // plain read also refreshes the pointer copy
        if (load_ptr) begin
          ptr_val <= data_in;
        end
      end
    end
  end

  // register goes out when written directly, or stored through a pointer
  assign save_reg = ((reg_op == OP_WRITE) && !is_reg_ptr) ||
                    ((reg_op == OP_WRITE_P) && is_reg_ptr);

  assign save_val = save_reg ? reg_val : ptr_val;

  // post-modify, wraps at DATA_W
  always_comb begin
    if (reg_op == OP_WRITE_P) begin
      // pointed-to store never modifies
      write_data = save_val;
    end else begin
      case (reg_step)
        STEP_INC: write_data = save_val + DATA_W'(1);
        STEP_DEC: write_data = save_val - DATA_W'(1);
        // none and the spare code
        default:  write_data = save_val;
      endcase
    end
  end

  // address selection
  assign ptr_op   = (reg_op == OP_READ_P) || (reg_op == OP_WRITE_P);
  assign ptr_addr = base_addr + ADDR_W'(ptr_val);
  assign num_addr = base_addr + ADDR_W'(reg_num);

  assign target_addr = ptr_op ? ptr_addr : num_addr;

  // outputs to the datapath
  assign register_out = reg_val;
  // pointer out carries the post-modified value
  assign reg_ptr_out  = write_data;

endmodule

// File: source/bus_sequencer.sv
`timescale 1ns/10ps

module bus_sequencer
  import reg_mgr_pkg::*;
#(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  // operation held by the controller
  input  reg_op_e           reg_op,
  // dispatcher grants the bus to this processor
  input  logic              disp_online,
  // memory side
  input  logic              is_bus_busy,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic [ADDR_W-1:0] addr_in,
  // request contents from the operand store
  input  logic [ADDR_W-1:0] target_addr,
  input  logic [DATA_W-1:0] write_data,
  // request strobes and payload
  output logic              read_q,
  output logic              write_q,
  output logic [ADDR_W-1:0] addr_out,
  output logic [DATA_W-1:0] data_out,
  // operand store controls
  output logic              catch_en,
  output logic              load_reg,
  output logic              load_ptr,
  // operation finished
  output logic              next_state
);

  seq_state_e state;

  // set by an offline cycle, cleared by an issue
  logic armed;
  // first cycle of a catch already taken
  logic catched;

  // registered strobes before online gating
  logic read_q_r;
  logic write_q_r;
  logic next_state_r;

  // latched request
  logic [ADDR_W-1:0] addr_r;
  logic [DATA_W-1:0] data_r;

  // operation class
  logic is_read_op;
  logic is_write_op;
  logic is_bus_op;

  // issue and completion decode
  logic issue;
  logic done_hit;
  logic accept;

  assign is_read_op  = (reg_op == OP_READ) || (reg_op == OP_READ_P);
  assign is_write_op = (reg_op == OP_WRITE) || (reg_op == OP_WRITE_P);
  assign is_bus_op   = is_read_op || is_write_op;

  // one request per online period
  // the next_state cycle belongs to the finished operation, so no issue there
  assign issue = (state == SEQ_IDLE) && is_bus_op && armed && disp_online &&
                 !is_bus_busy && !next_state_r;

  // completion type has to match the operation class
  always_comb begin
    if (is_read_op) begin
      done_hit = read_dn;
    end else if (is_write_op) begin
      done_hit = write_dn;
    end else begin
      done_hit = 1'b0;
    end
  end

  // foreign completions carry another address and are ignored
  assign accept = (state != SEQ_IDLE) && is_bus_busy && done_hit &&
                  (addr_in == addr_r);

  // register loads happen in the completion edge itself
  assign load_reg = accept && is_read_op;
  assign load_ptr = accept && (reg_op == OP_READ);

  // capture only on the first catch cycle
  assign catch_en = (reg_op == OP_CATCH) && !catched;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= SEQ_IDLE;
      armed        <= 1'b0;
      catched      <= 1'b0;
      read_q_r     <= 1'b0;
      write_q_r    <= 1'b0;
      next_state_r <= 1'b0;
    end else begin
      // rearm whenever the dispatcher takes us offline
      if (issue) begin
        armed <= 1'b0;
      end else if (!disp_online) begin
        armed <= 1'b1;
      end

      // drops as soon as the controller leaves catch
      catched <= (reg_op == OP_CATCH);

      // strobe is high only in the SEQ_REQ cycle
      read_q_r  <= issue && is_read_op;
      write_q_r <= issue && is_write_op;

      // done after a matching completion, or every catch cycle
      next_state_r <= accept || (reg_op == OP_CATCH);

      case (state)
        SEQ_IDLE: begin
          if (issue) begin
            state <= SEQ_REQ;
          end
        end
        SEQ_REQ: begin
          // fast memory may answer right behind the strobe
          if (accept) begin
            state <= SEQ_IDLE;
          end else begin
            state <= SEQ_WAIT;
          end
        end
        SEQ_WAIT: begin
          // no timeout, the request waits as long as memory needs
          if (accept) begin
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // request payload, held until the next issue
  always_ff @(posedge clk) begin
    if (issue) begin
      addr_r <= target_addr;
      data_r <= write_data;
    end
  end

  // strobes never leave while offline
  assign read_q  = read_q_r && disp_online;
  assign write_q = write_q_r && disp_online;

  // address only for bus operations while online
  assign addr_out = (is_bus_op && disp_online) ? addr_r : '0;
  // data only for stores while online
  assign data_out = (is_write_op && disp_online) ? data_r : '0;

  assign next_state = next_state_r;

endmodule

// File: source/register_manager.sv
`timescale 1ns/10ps

module register_manager
  import reg_mgr_pkg::*;
#(
  // memory address width
  parameter int ADDR_W = 32,
  // register and data width
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  // controller side
  input  reg_op_e           reg_op,
  input  logic [3:0]        reg_num,
  input  logic [ADDR_W-1:0] base_addr,
  input  logic              is_reg_ptr,
  input  step_e             reg_step,
  input  logic              alu_result,
  input  logic [DATA_W-1:0] register_in,
  input  logic [DATA_W-1:0] reg_ptr_in,
  // dispatcher
  input  logic              disp_online,
  // memory side
  input  logic              is_bus_busy,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic [ADDR_W-1:0] addr_in,
  input  logic [DATA_W-1:0] data_in,
  // operands back to the datapath
  output logic [DATA_W-1:0] register_out,
  output logic [DATA_W-1:0] reg_ptr_out,
  // bus request
  output logic              read_q,
  output logic              write_q,
  output logic [ADDR_W-1:0] addr_out,
  output logic [DATA_W-1:0] data_out,
  // operation finished
  output logic              next_state
);

  // sequencer to store
  logic              catch_en;
  logic              load_reg;
  logic              load_ptr;
  // store to sequencer
  logic [ADDR_W-1:0] target_addr;
  logic [DATA_W-1:0] write_data;

  // held values, post-modify and address select
  operand_store #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_store (
    .clk          (clk),
    .rst          (rst),
    .reg_op       (reg_op),
    .reg_num      (reg_num),
    .base_addr    (base_addr),
    .is_reg_ptr   (is_reg_ptr),
    .reg_step     (reg_step),
    .alu_result   (alu_result),
    .register_in  (register_in),
    .reg_ptr_in   (reg_ptr_in),
    .catch_en     (catch_en),
    .load_reg     (load_reg),
    .load_ptr     (load_ptr),
    .data_in      (data_in),
    .register_out (register_out),
    .reg_ptr_out  (reg_ptr_out),
    .target_addr  (target_addr),
    .write_data   (write_data)
  );

  // bus requests and done pulses
  bus_sequencer #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_seq (
    .clk         (clk),
    .rst         (rst),
    .reg_op      (reg_op),
    .disp_online (disp_online),
    .is_bus_busy (is_bus_busy),
    .read_dn     (read_dn),
    .write_dn    (write_dn),
    .addr_in     (addr_in),
    .target_addr (target_addr),
    .write_data  (write_data),
    .read_q      (read_q),
    .write_q     (write_q),
    .addr_out    (addr_out),
    .data_out    (data_out),
    .catch_en    (catch_en),
    .load_reg    (load_reg),
    .load_ptr    (load_ptr),
    .next_state  (next_state)
  );

endmodule

// File: dv/register_manager_asserts.sv
`timescale 1ns/10ps

module register_manager_asserts
  import reg_mgr_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input reg_op_e    reg_op,
  input logic       disp_online,
  input logic       read_q,
  input logic       write_q,
  input logic       next_state
);

  // number of failed properties so far
  int fail_count = 0;

  task automatic note_failure(input string msg);
    $error("%s", msg);
    fail_count++;
  endtask

  // read and write strobes are exclusive
  no_double_strobe: assert property (@(posedge clk) disable iff (rst)
    !(read_q && write_q))
    else note_failure("read_q and write_q high together");

  // strobe lasts exactly one cycle
  one_cycle_strobe: assert property (@(posedge clk) disable iff (rst)
    (read_q || write_q) |=> !(read_q || write_q))
    else note_failure("bus strobe longer than one cycle");

  // nothing leaves while the dispatcher has us offline
  no_offline_strobe: assert property (@(posedge clk) disable iff (rst)
    !disp_online |-> !(read_q || write_q))
    else note_failure("bus strobe while offline");

  // bus operations finish with a single done pulse
  one_cycle_done: assert property (@(posedge clk) disable iff (rst)
    (next_state && (reg_op inside {OP_READ, OP_READ_P, OP_WRITE, OP_WRITE_P}))
      |=> !next_state)
    else note_failure("next_state longer than one cycle for a bus operation");

endmodule

bind bus_sequencer register_manager_asserts u_asserts (.*);

// File: dv/tb_register_manager.sv
`timescale 1ns/10ps

module tb_register_manager
  import reg_mgr_pkg::*;
();

  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  // five directed operations before the random ones
  localparam int NUM_OPS = 60;
  // an operation takes about 18 cycles at worst on top of reset
  localparam int CYCLE_LIMIT = NUM_OPS * 20 + 8;

  logic clk = 1'b0;
  logic rst;
  reg_op_e reg_op;
  logic [3:0] reg_num;
  logic [ADDR_W-1:0] base_addr;
  logic is_reg_ptr;
  step_e reg_step;
  logic alu_result;
  logic [DATA_W-1:0] register_in;
  logic [DATA_W-1:0] reg_ptr_in;
  logic disp_online;
  logic is_bus_busy;
  logic read_dn;
  logic write_dn;
  logic [ADDR_W-1:0] addr_in;
  logic [DATA_W-1:0] data_in;
  logic [DATA_W-1:0] register_out;
  logic [DATA_W-1:0] reg_ptr_out;
  logic read_q;
  logic write_q;
  logic [ADDR_W-1:0] addr_out;
  logic [DATA_W-1:0] data_out;
  logic next_state;

  // memory model holding written words only
  logic [31:0] mem [logic [31:0]];
  logic [31:0] rng;
  logic [31:0] fill_key;
  // model of the held register and pointer
  logic [31:0] m_reg;
  logic [31:0] m_ptr;
  // request expected at the next strobe
  logic        exp_valid;
  logic        exp_wr;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;
  logic        hold_check;
  int err_count;
  int check_count;
  int cycles;
  // checker bookkeeping
  int          strobes_online;
  logic [31:0] last_req_addr;
  logic        prev_match;
  logic        prev_catch;

  register_manager #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) i_dut (.*);

  always #50 clk = ~clk;

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles, an operation never finished", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // unwritten words come from a pattern over every address bit
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ fill_key;
  endfunction

  // expected request address and store data for an operation
  function automatic void ref_request(input reg_op_e op, input logic [3:0] num,
                                      input logic [31:0] base, input logic ptr_flag,
                                      input step_e step, input logic [31:0] rv,
                                      input logic [31:0] pv, output logic [31:0] addr,
                                      output logic [31:0] data);
    logic [31:0] save;
    logic        use_reg;
    use_reg = ((op == OP_WRITE) && !ptr_flag) || ((op == OP_WRITE_P) && ptr_flag);
    save = use_reg ? rv : pv;
    if (op == OP_WRITE_P) begin
      data = save;
    end else if (step == STEP_INC) begin
      data = save + 32'd1;
    end else if (step == STEP_DEC) begin
      data = save - 32'd1;
    end else begin
      data = save;
    end
    if ((op == OP_READ_P) || (op == OP_WRITE_P)) begin
      addr = base + pv;
    end else begin
      addr = base + {28'd0, num};
    end
  endfunction

  task automatic wrong_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    err_count++;
    $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic protocol_problem(input string msg);
    err_count++;
    $display("%s at %0t", msg, $time);
  endtask

  // comparing process sampling values settled since the falling edge
  always @(posedge clk) begin
    if (!rst) begin
      if (!disp_online) begin
        strobes_online = 0;
      end else if (read_q || write_q) begin
        strobes_online++;
      end
      if (strobes_online > 1) begin
        protocol_problem("more than one request in one online period");
      end
      if (read_q || write_q) begin
        check_count++;
        last_req_addr = addr_out;
        if (!exp_valid) begin
          protocol_problem("bus strobe with no armed operation");
        end else begin
          if (write_q != exp_wr) begin
            wrong_value("write_q", 32'(write_q), 32'(exp_wr));
          end
          if (addr_out != exp_addr) begin
            wrong_value("addr_out", addr_out, exp_addr);
          end
          if (write_q && (data_out != exp_data)) begin
            wrong_value("data_out", data_out, exp_data);
          end
        end
      end
      // gating of the payload
      if (((reg_op == OP_NOP) || (reg_op == OP_CATCH)) && (addr_out != '0)) begin
        wrong_value("addr_out", addr_out, 32'h0);
      end
      if ((reg_op != OP_WRITE) && (reg_op != OP_WRITE_P) && (data_out != '0)) begin
        wrong_value("data_out", data_out, 32'h0);
      end
      if (next_state && !prev_match && !prev_catch) begin
        protocol_problem("next_state pulsed without a matching completion or catch");
      end
      // each matching completion and each held catch cycle is answered
      if ((prev_match || prev_catch) && !next_state) begin
        protocol_problem("next_state missing after a matching completion or catch");
      end
      prev_match = (read_dn || write_dn) && is_bus_busy && (addr_in == last_req_addr);
      prev_catch = (reg_op == OP_CATCH);
      // held values between operations
      if (hold_check) begin
        check_count++;
        if (register_out != m_reg) begin
          wrong_value("register_out", register_out, m_reg);
        end
        if (reg_ptr_out != m_ptr) begin
          wrong_value("reg_ptr_out", reg_ptr_out, m_ptr);
        end
      end
    end
  end

  // memory answers each strobe after 1 to 6 busy cycles
  initial begin : memory_model
    logic [31:0] req_addr;
    logic [31:0] req_data;
    logic [31:0] junk;
    logic        req_wr;
    logic        foreign;
    int          lat;
    forever begin
      @(posedge clk);
      if (!rst && (read_q || write_q)) begin
        req_addr = addr_out;
        req_data = data_out;
        req_wr   = write_q;
        junk     = next_rand();
        lat      = 1 + int'(junk[2:0]) % 6;
        foreign  = (junk[4:3] == 2'b00);
        @(negedge clk);
        is_bus_busy = 1'b1;
        for (int i = 0; i < lat; i++) begin
          // stray completion for another processor's address
          if (foreign && (i == 0)) begin
            addr_in  = req_addr ^ 32'h4;
            data_in  = junk;
            read_dn  = !req_wr;
            write_dn = req_wr;
          end
          @(negedge clk);
          read_dn  = 1'b0;
          write_dn = 1'b0;
        end
        if (req_wr) begin
          mem[req_addr] = req_data;
        end else begin
          data_in = mem_word(req_addr);
        end
        addr_in  = req_addr;
        read_dn  = !req_wr;
        write_dn = req_wr;
        @(negedge clk);
        read_dn     = 1'b0;
        write_dn    = 1'b0;
        is_bus_busy = 1'b0;
      end
    end
  end

  task automatic wait_next_state();
    @(posedge clk);
    while (!next_state) begin
      @(posedge clk);
    end
  endtask

  // one read or write armed by a short offline gap
  task automatic bus_operation(input reg_op_e op);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    @(negedge clk);
    hold_check = 1'b0;
    r = next_rand();
    reg_op     = op;
    reg_num    = r[3:0];
    is_reg_ptr = r[4];
    reg_step   = step_e'(r[6:5]);
    base_addr  = next_rand();
    ref_request(op, reg_num, base_addr, is_reg_ptr, reg_step, m_reg, m_ptr, a, d);
    exp_addr = a;
    exp_data = d;
    exp_wr   = (op == OP_WRITE) || (op == OP_WRITE_P);
    // still online from the last period, so no request may go out
    repeat (int'(r[9:8])) @(negedge clk);
    exp_valid   = 1'b1;
    disp_online = 1'b0;
    repeat (1 + int'(r[10])) @(negedge clk);
    disp_online = 1'b1;
    wait_next_state();
    if (!exp_wr) begin
      m_reg = mem_word(a);
      // plain read refreshes the pointer copy too
      if (op == OP_READ) begin
        m_ptr = mem_word(a);
      end
    end
  endtask

  task automatic catch_operation();
    logic [31:0] r;
    @(negedge clk);
    hold_check = 1'b0;
    r = next_rand();
    alu_result  = r[0];
    register_in = next_rand();
    reg_ptr_in  = next_rand();
    reg_op      = OP_CATCH;
    if (alu_result) begin
      m_reg = register_in;
    end else begin
      m_reg = reg_ptr_in;
      m_ptr = reg_ptr_in;
    end
    wait_next_state();
    // later cycles of a held catch capture nothing
    if (r[1]) begin
      @(negedge clk);
      register_in = next_rand();
      reg_ptr_in  = next_rand();
      @(posedge clk);
    end
  endtask

  // back to idle with held values checked
  task automatic settle();
    @(negedge clk);
    exp_valid  = 1'b0;
    reg_op     = OP_NOP;
    reg_step   = STEP_NONE;
    hold_check = 1'b1;
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] r;
    int          k;
    int          asserts_failed;
    rng = 32'h13b3;
    fill_key = next_rand();
    rst = 1'b1;
    reg_op = OP_NOP;
    reg_num = '0;
    base_addr = '0;
    is_reg_ptr = 1'b0;
    reg_step = STEP_NONE;
    alu_result = 1'b0;
    register_in = '0;
    reg_ptr_in = '0;
    disp_online = 1'b1;
    is_bus_busy = 1'b0;
    read_dn = 1'b0;
    write_dn = 1'b0;
    addr_in = '0;
    data_in = '0;
    m_reg = '0;
    m_ptr = '0;
    exp_valid = 1'b0;
    exp_wr = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    hold_check = 1'b0;
    err_count = 0;
    check_count = 0;
    cycles = 0;
    strobes_online = 0;
    last_req_addr = '0;
    prev_match = 1'b0;
    prev_catch = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_OPS; i++) begin
      r = next_rand();
      // each kind once up front
      k = (i < 5) ? i : int'(r % 32'd5);
      case (k)
        0: catch_operation();
        1: bus_operation(OP_READ);
        2: bus_operation(OP_READ_P);
        3: bus_operation(OP_WRITE);
        default: bus_operation(OP_WRITE_P);
      endcase
      settle();
    end
    asserts_failed = i_dut.u_seq.u_asserts.fail_count;
    $display("errors: %0d, assertion failures: %0d, checks: %0d",
             err_count, asserts_failed, check_count);
    if ((err_count == 0) && (asserts_failed == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
source/reg_mgr_pkg.sv
source/operand_store.sv
source/bus_sequencer.sv
source/register_manager.sv
dv/register_manager_asserts.sv
dv/tb_register_manager.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_register_manager -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0
